// ==== Makefile ====
LOG = sim.log

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module fml_subsystem_tb -Mdir obj_dir -o fml_sim -f fml_subsystem.f

run: compile
	-obj_dir/fml_sim > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: compile run clean

// ==== fml_subsystem.f ====
+incdir+hw
hw/fml_pkg.sv
hw/reset_gen.sv
hw/fml_arbiter.sv
hw/fml_mem.sv
hw/wb_fml_bridge.sv
hw/fb_scanout.sv
hw/fml_subsystem.sv
verif/fml_subsystem_props.sv
verif/fml_subsystem_tb.sv

// ==== hw/fb_scanout.sv ====
// Framebuffer reader, one memory word fetched at a time
// Words split into 16-bit pixels, lowest first, one per cycle
`timescale 1ns/10ps
`include "fml_macros.svh"

module fb_scanout (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  start_i,
	input  logic [`FML_DEPTH-4:0] base_i,
	input  logic [7:0]            words_i,
	output logic                  busy_o,
	output logic                  pix_valid_o,
	output logic [15:0]           pix_o,
	output fml_pkg::fml_req_t     fml_req_o,
	input  logic                  fml_ack_i,
	input  fml_pkg::fml_word_u    fml_dr_i
);

	logic                  stb_q;
	// Word address of the fetch in flight or next
	logic [`FML_DEPTH-4:0] adr_q;
	// Words still to fetch
	logic [7:0]            left_q;
	// Two-entry buffer, shift word and pending word
	fml_pkg::fml_word_u    shift_q;
	fml_pkg::fml_word_u    pend_q;
	logic                  shift_vld;
	logic                  pend_vld;
	logic [1:0]            pix_idx;
	logic                  got_word;
	logic                  last_pix;
	logic                  shift_free;
	logic                  start;

	assign start      = start_i && !busy_o;
	assign got_word   = stb_q && fml_ack_i;
	assign last_pix   = shift_vld && (pix_idx == 2'd3);
	// Shift word can be replaced this cycle
	assign shift_free = !shift_vld || last_pix;

	// Read-only master
	assign fml_req_o = '{stb: stb_q, we: 1'b0, adr: {adr_q, 3'b000},
		sel: {`FML_SELW{1'b1}}, dw: {`FML_DW{1'b0}}};

	// --------------------------------------------------
	// Fetch and buffer control
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			stb_q       <= 1'b0;
			left_q      <= 8'd0;
			shift_vld   <= 1'b0;
			pend_vld    <= 1'b0;
			pix_idx     <= 2'd0;
			pix_valid_o <= 1'b0;
			busy_o      <= 1'b0;
		end else begin
			pix_valid_o <= shift_vld;
			if (start) begin
				busy_o <= 1'b1;
				left_q <= words_i;
			end else if (busy_o && !stb_q && left_q == 8'd0 && !pend_vld && !shift_vld) begin
				// Last pixel already out
				busy_o <= 1'b0;
			end
			// Next fetch only with a free pending slot
			if (got_word) begin
				stb_q  <= 1'b0;
				left_q <= left_q - 8'd1;
			end else if (!stb_q && left_q != 8'd0 && !pend_vld) begin
				stb_q <= 1'b1;
			end
			// Index wraps to zero after the fourth pixel
			if (shift_vld)
				pix_idx <= pix_idx + 2'd1;
			if (got_word && !shift_free) begin
				pend_vld <= 1'b1;
			end else if (shift_free && pend_vld) begin
				pend_vld <= 1'b0;
			end
			if (shift_free)
				shift_vld <= got_word || pend_vld;
		end
	end

	// Address, buffer words and pixel out
	always_ff @(posedge sys_clk) begin
		if (start) begin
			adr_q <= base_i;
		end else if (got_word) begin
			adr_q <= adr_q + 1'b1;
		end
		if (got_word && !shift_free)
			pend_q <= fml_dr_i;
		// Pending word first, it is older
		if (shift_free)
			shift_q <= pend_vld ? pend_q : fml_dr_i;
		if (shift_vld)
			pix_o <= shift_q.pix[pix_idx];
	end

endmodule

// ==== hw/fml_arbiter.sv ====
// Fixed-priority arbiter sharing one memory port between two masters
// Master 0 is the scanout and always wins a tie
`timescale 1ns/10ps

module fml_arbiter (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  fml_pkg::fml_req_t m0_req_i,
	output logic              m0_ack_o,
	input  fml_pkg::fml_req_t m1_req_i,
	output logic              m1_ack_o,
	output fml_pkg::fml_req_t s_req_o,
	input  logic              s_ack_i
);

	// Registered owner of the memory port
	logic owner;
	logic owner_stb;
	logic rearb;
	logic next_owner;

	assign owner_stb = owner ? m1_req_i.stb : m0_req_i.stb;

	// Port is free when the owner is idle or its ack is on the bus
	// Memory restarts its latency count in both cases
	assign rearb = !owner_stb || s_ack_i;

	// Priority pick, keep current owner when nobody asks
	always_comb begin
		next_owner = owner;
		if (m0_req_i.stb) begin
			next_owner = 1'b0;
		end else if (m1_req_i.stb) begin
			next_owner = 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			owner <= 1'b0;
		end else if (rearb) begin
			owner <= next_owner;
		end
	end

	// --------------------------------------------------
	// Request mux and ack steering
	// --------------------------------------------------
	assign s_req_o = owner ? m1_req_i : m0_req_i;

	// Ack to the owner only
	assign m0_ack_o = s_ack_i && !owner;
	assign m1_ack_o = s_ack_i && owner;

endmodule

// ==== hw/fml_macros.svh ====
// Widths, depths, counter sizes and latency of the fast memory link subsystem
`ifndef FML_MACROS_SVH
`define FML_MACROS_SVH

// Byte address width of the shared memory, 4 KiB on chip
`define FML_DEPTH       12
// Memory word and byte-enable widths
`define FML_DW          64
`define FML_SELW        8
// Host bus data width
`define WB_DW           32

// Reset hold counter, short for simulation
`define RST_DEBOUNCE_W  6
// Flash reset counter; its top bit must set before the hold counter empties
`define FLASH_RST_W     6

// Cycles from first strobe to acknowledge
`define MEM_LATENCY     2

`endif

// ==== hw/fml_mem.sv ====
// On-chip memory model on the fast memory link
// Byte-enabled writes, fixed acknowledge latency
`timescale 1ns/10ps
`include "fml_macros.svh"

module fml_mem (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  fml_pkg::fml_req_t  req_i,
	output logic               ack_o,
	output fml_pkg::fml_word_u dr_o
);

	localparam int WORDS = 1 << (`FML_DEPTH - 3);
	localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

	logic [`FML_DW-1:0]    mem [WORDS];
	logic [LAT_W-1:0]      lat_cnt;
	logic [`FML_DEPTH-4:0] word_idx;
	logic                  hit;

	// Byte address to word index
	assign word_idx = req_i.adr[`FML_DEPTH-1:3];

	// Access lands when the count reaches latency
	// Strobe still high in the ack cycle is the finished request
	assign hit = req_i.stb && !ack_o && (lat_cnt == LAT_W'(`MEM_LATENCY - 1));

	// --------------------------------------------------
	// Latency counter and ack
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			lat_cnt <= '0;
			ack_o   <= 1'b0;
		end else begin
			ack_o <= hit;
			// Restart on idle, on completion and on the ack cycle
			if (!req_i.stb || ack_o || hit) begin
				lat_cnt <= '0;
			end else begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	// Array access, read word valid together with ack
	always_ff @(posedge sys_clk) begin
		if (hit) begin
			if (req_i.we) begin
				for (int i = 0; i < `FML_SELW; i++) begin
					if (req_i.sel[i])
						mem[word_idx][8*i +: 8] <= req_i.dw[8*i +: 8];
				end
			end else begin
				dr_o <= mem[word_idx];
			end
		end
	end

endmodule

// ==== hw/fml_pkg.sv ====
// Shared types of the fast memory link subsystem
// Memory request, host bus request and the two views of a memory word
`include "fml_macros.svh"

package fml_pkg;

	// One request on the fast memory link
	typedef struct packed {
		logic                  stb;
		logic                  we;
		logic [`FML_DEPTH-1:0] adr;
		logic [`FML_SELW-1:0]  sel;
		logic [`FML_DW-1:0]    dw;
	} fml_req_t;

	// Host bus cycle, Wishbone classic
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [31:0]       adr;
		logic [3:0]        sel;
		logic [`WB_DW-1:0] dat;
	} wb_req_t;

	// --------------------------------------------------
	// Memory word views
	// Bridge picks a 32-bit half by address bit 2
	// Scanout walks four 16-bit pixels, lowest first
	// --------------------------------------------------
	typedef union packed {
		logic [`FML_DW/`WB_DW-1:0][`WB_DW-1:0] half;
		logic [`FML_DW/16-1:0][15:0]           pix;
	} fml_word_u;

endpackage

// ==== hw/fml_subsystem.sv ====
// Memory side of the video SoC
// Reset sequencing, scanout and host bridge sharing one memory
`timescale 1ns/10ps
`include "fml_macros.svh"

module fml_subsystem (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,
	input  fml_pkg::wb_req_t      wb_i,
	output logic [`WB_DW-1:0]     wb_dat_o,
	output logic                  wb_ack_o,
	input  logic                  scan_start_i,
	input  logic [`FML_DEPTH-4:0] scan_base_i,
	input  logic [7:0]            scan_words_i,
	output logic                  scan_busy_o,
	output logic                  pix_valid_o,
	output logic [15:0]           pix_o,
	output logic                  periph_rst_n_o,
	output logic                  flash_rst_n_o
);

	logic               sys_rst;
	// Master side, scanout and bridge
	fml_pkg::fml_req_t  fml_scan_req;
	fml_pkg::fml_req_t  fml_brg_req;
	logic               fml_scan_ack;
	logic               fml_brg_ack;
	// Memory side
	fml_pkg::fml_req_t  fml_req;
	logic               fml_ack;
	// Read word goes to both masters
	fml_pkg::fml_word_u fml_dr;

	// --------------------------------------------------
	// Reset
	// --------------------------------------------------
	reset_gen reset_gen_inst (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// --------------------------------------------------
	// Shared memory
	// --------------------------------------------------
	fml_arbiter fml_arbiter_inst (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.m0_req_i (fml_scan_req),
		.m0_ack_o (fml_scan_ack),
		.m1_req_i (fml_brg_req),
		.m1_ack_o (fml_brg_ack),
		.s_req_o  (fml_req),
		.s_ack_i  (fml_ack)
	);

	fml_mem fml_mem_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.req_i   (fml_req),
		.ack_o   (fml_ack),
		.dr_o    (fml_dr)
	);

	// Masters
	wb_fml_bridge wb_fml_bridge_inst (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.wb_i      (wb_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.fml_req_o (fml_brg_req),
		.fml_ack_i (fml_brg_ack),
		.fml_dr_i  (fml_dr)
	);

	fb_scanout fb_scanout_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (scan_start_i),
		.base_i      (scan_base_i),
		.words_i     (scan_words_i),
		.busy_o      (scan_busy_o),
		.pix_valid_o (pix_valid_o),
		.pix_o       (pix_o),
		.fml_req_o   (fml_scan_req),
		.fml_ack_i   (fml_scan_ack),
		.fml_dr_i    (fml_dr)
	);

endmodule

// ==== hw/reset_gen.sv ====
// Debounced system reset and early flash reset release
`timescale 1ns/10ps
`include "fml_macros.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic [`RST_DEBOUNCE_W-1:0] rst_debounce;
	logic [`FLASH_RST_W-1:0]    flash_cnt;

	// --------------------------------------------------
	// System reset hold
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		// Reload on every trigger, then count down to zero
		if (trigger_reset) begin
			rst_debounce <= '1;
		end else if (rst_debounce != '0) begin
			rst_debounce <= rst_debounce - 1'b1;
		end
		// One register stage after the counter
		sys_rst_o <= (rst_debounce != '0);
	end

	// --------------------------------------------------
	// Flash reset, released well before the system reset
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			flash_cnt <= '0;
		end else if (!flash_cnt[`FLASH_RST_W-1]) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	// Top bit sticks once set
	assign flash_rst_n_o = flash_cnt[`FLASH_RST_W-1];

endmodule

// ==== hw/wb_fml_bridge.sv ====
// Host bus to fast memory link bridge
// 32-bit cycles mapped onto one half of a 64-bit word
`timescale 1ns/10ps
`include "fml_macros.svh"

module wb_fml_bridge (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  fml_pkg::wb_req_t   wb_i,
	output logic [`WB_DW-1:0]  wb_dat_o,
	output logic               wb_ack_o,
	output fml_pkg::fml_req_t  fml_req_o,
	input  logic               fml_ack_i,
	input  fml_pkg::fml_word_u fml_dr_i
);

	logic                  stb_q;
	logic                  we_q;
	logic [`FML_DEPTH-1:0] adr_q;
	logic [`FML_SELW-1:0]  sel_q;
	fml_pkg::fml_word_u    dw_q;
	// Held from issue through the host ack cycle
	logic                  busy;
	logic                  wb_req;
	logic                  issue;

	assign wb_req = wb_i.cyc && wb_i.stb;
	assign issue  = !stb_q && wb_req && !busy;

	// --------------------------------------------------
	// Cycle control
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			stb_q    <= 1'b0;
			busy     <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			if (stb_q) begin
				// Host ack one cycle after memory ack
				if (fml_ack_i) begin
					stb_q    <= 1'b0;
					wb_ack_o <= 1'b1;
				end
			end else if (issue) begin
				stb_q <= 1'b1;
				busy  <= 1'b1;
			end else if (wb_ack_o) begin
				// Host saw ack, a strobe next cycle is a new cycle
				busy <= 1'b0;
			end
		end
	end

	// Request payload and read half
	always_ff @(posedge sys_clk) begin
		if (issue) begin
			we_q      <= wb_i.we;
			adr_q     <= wb_i.adr[`FML_DEPTH-1:0];
			sel_q     <= wb_i.adr[2] ? {wb_i.sel, 4'h0} : {4'h0, wb_i.sel};
			// Same data in both halves, sel picks the live one
			dw_q.half <= {wb_i.dat, wb_i.dat};
		end
		if (stb_q && fml_ack_i)
			wb_dat_o <= fml_dr_i.half[adr_q[2]];
	end

	assign fml_req_o = '{stb: stb_q, we: we_q, adr: adr_q, sel: sel_q, dw: dw_q};

endmodule

// ==== verif/fml_golden.txt ====
# W <byte adr> <sel> <data>  |  R <byte adr> <expected data>
# S <word base> <words> <expected pixels, lowest first>
W 104 f aabbccdd
W 100 f 11223344
R 104 aabbccdd
R 100 11223344
W 100 6 55667788
R 100 11667744
R 104 aabbccdd
W 200 f 22221111
W 204 f 44443333
W 208 f 66665555
W 20c f 88887777
W 210 f aaaa9999
W 214 f ccccbbbb
S 40 2 1111 2222 3333 4444 5555 6666 7777 8888
S 40 3 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc
R 100 11667744
W 300 f cafef00d
R 300 cafef00d
R 104 aabbccdd

// ==== verif/fml_subsystem_props.sv ====
// Bound checks on the memory arbiter
// Exclusive acks, ack only on request, quiet reset, bounded wait
`timescale 1ns/10ps

module fml_arbiter_props (
	input logic              sys_clk,
	input logic              sys_rst,
	input fml_pkg::fml_req_t m0_req_i,
	input fml_pkg::fml_req_t m1_req_i,
	input logic              m0_ack_i,
	input logic              m1_ack_i
);

	// Failed assertions so far
	int         fail_cnt = 0;
	// Cycles each master has strobed without ack
	logic [4:0] m0_wait;
	logic [4:0] m1_wait;

	always_ff @(posedge sys_clk) begin
		if (sys_rst !== 1'b0 || !m0_req_i.stb || m0_ack_i) begin
			m0_wait <= '0;
		end else if (m0_wait != 5'd31) begin
			m0_wait <= m0_wait + 5'd1;
		end
		if (sys_rst !== 1'b0 || !m1_req_i.stb || m1_ack_i) begin
			m1_wait <= '0;
		end else if (m1_wait != 5'd31) begin
			m1_wait <= m1_wait + 5'd1;
		end
	end

	// --------------------------------------------------
	// Ack steering
	// --------------------------------------------------
	// One master per ack and no ack to either master right after it
	ack_exclusive: assert property (@(posedge sys_clk) disable iff (sys_rst !== 1'b0)
		(m0_ack_i || m1_ack_i) |-> !(m0_ack_i && m1_ack_i) ##1 (!m0_ack_i && !m1_ack_i))
		else begin
			$error("acks overlap or follow each other");
			fail_cnt = fail_cnt + 1;
		end

	ack_on_stb: assert property (@(posedge sys_clk) disable iff (sys_rst !== 1'b0)
		(!m0_ack_i || m0_req_i.stb) && (!m1_ack_i || m1_req_i.stb))
		else begin
			$error("ack given to a master without strobe");
			fail_cnt = fail_cnt + 1;
		end

	// Ack is registered and clean from the second reset cycle on
	quiet_reset: assert property (@(posedge sys_clk)
		sys_rst && $past(sys_rst) |-> !m0_ack_i && !m1_ack_i)
		else begin
			$error("ack during reset");
			fail_cnt = fail_cnt + 1;
		end

	bounded_wait: assert property (@(posedge sys_clk) disable iff (sys_rst !== 1'b0)
		m0_wait < 5'd16 && m1_wait < 5'd16)
		else begin
			$error("strobe held 16 cycles without ack");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind fml_arbiter fml_arbiter_props fml_arbiter_props_inst (
	.sys_clk  (sys_clk),
	.sys_rst  (sys_rst),
	.m0_req_i (m0_req_i),
	.m1_req_i (m1_req_i),
	.m0_ack_i (m0_ack_o),
	.m1_ack_i (m1_ack_o)
);

// ==== verif/fml_subsystem_tb.sv ====
// Testbench of the memory subsystem driven by the golden file
// Reset order, host writes and reads, scanouts alone and shared
`timescale 1ns/10ps
`include "fml_macros.svh"

module fml_subsystem_tb;

	localparam int WAIT_LIMIT = 200;

	logic                  sys_clk;
	logic                  trigger_reset;
	fml_pkg::wb_req_t      wb_i;
	logic [`WB_DW-1:0]     wb_dat_o;
	logic                  wb_ack_o;
	logic                  scan_start_i;
	logic [`FML_DEPTH-4:0] scan_base_i;
	logic [7:0]            scan_words_i;
	logic                  scan_busy_o;
	logic                  pix_valid_o;
	logic [15:0]           pix_o;
	logic                  periph_rst_n_o;
	logic                  flash_rst_n_o;

	int          seed = 62;
	int          fd;
	int          val_errs = 0;
	int          proto_errs = 0;
	int          prop_errs;
	logic        scan_running = 1'b0;
	// Pixels still expected from the running scan
	logic [15:0] exp_pix [$];

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	fml_subsystem fml_subsystem_inst (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_i           (wb_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.scan_start_i   (scan_start_i),
		.scan_base_i    (scan_base_i),
		.scan_words_i   (scan_words_i),
		.scan_busy_o    (scan_busy_o),
		.pix_valid_o    (pix_valid_o),
		.pix_o          (pix_o),
		.periph_rst_n_o (periph_rst_n_o),
		.flash_rst_n_o  (flash_rst_n_o)
	);

	// --------------------------------------------------
	// Reset release order with outputs quiet meanwhile
	// --------------------------------------------------
	task automatic check_reset_order();
		int   t;
		logic flash_seen;
		t = 0;
		flash_seen = 1'b0;
		// Flash held in reset when trigger falls
		if (flash_rst_n_o !== 1'b0) begin
			$display("error at %0t: flash_rst_n_o expected 0 actual %b", $time, flash_rst_n_o);
			val_errs++;
		end
		while (periph_rst_n_o !== 1'b1 && t < WAIT_LIMIT) begin
			if (wb_ack_o !== 1'b0) begin
				$display("error at %0t: wb_ack_o expected 0 actual %b", $time, wb_ack_o);
				val_errs++;
			end
			if (pix_valid_o !== 1'b0) begin
				$display("error at %0t: pix_valid_o expected 0 actual %b", $time, pix_valid_o);
				val_errs++;
			end
			if (scan_busy_o !== 1'b0) begin
				$display("error at %0t: scan_busy_o expected 0 actual %b", $time, scan_busy_o);
				val_errs++;
			end
			flash_seen = flash_seen | (flash_rst_n_o === 1'b1);
			@(negedge sys_clk);
			t++;
		end
		if (periph_rst_n_o !== 1'b1) begin
			$display("periph_rst_n_o never rose after reset");
			proto_errs++;
		end
		if (!flash_seen) begin
			$display("flash_rst_n_o did not rise before periph_rst_n_o");
			proto_errs++;
		end
	endtask

	// One Wishbone classic cycle with strobe held until ack
	task automatic host_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat, output logic [31:0] rdat);
		int t;
		t = 0;
		@(negedge sys_clk);
		wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
		@(negedge sys_clk);
		while (!wb_ack_o && t < WAIT_LIMIT) begin
			@(negedge sys_clk);
			t++;
		end
		rdat = wb_dat_o;
		if (!wb_ack_o) begin
			$display("host cycle at address %h got no ack", adr);
			proto_errs++;
		end
		wb_i.cyc = 1'b0;
		wb_i.stb = 1'b0;
	endtask

	// --------------------------------------------------
	// Scanout
	// --------------------------------------------------
	task automatic collect_scan();
		int          n_pix;
		int          got;
		int          t;
		logic [15:0] exp;
		n_pix = exp_pix.size();
		got = 0;
		t = 0;
		while (got < n_pix && t < WAIT_LIMIT) begin
			@(negedge sys_clk);
			t++;
			if (pix_valid_o) begin
				exp = exp_pix.pop_front();
				if (pix_o !== exp) begin
					$display("error at %0t: pix_o expected %h actual %h", $time, exp, pix_o);
					val_errs++;
				end
				// Busy until the last pixel is out
				if (scan_busy_o !== 1'b1) begin
					$display("error at %0t: scan_busy_o expected 1 actual %b",
						$time, scan_busy_o);
					val_errs++;
				end
				got++;
				t = 0;
			end
		end
		if (got < n_pix) begin
			$display("scanout stopped after %0d of %0d pixels", got, n_pix);
			proto_errs++;
		end
		// No pixel beyond the word count while busy drains
		t = 0;
		while (scan_busy_o && t < WAIT_LIMIT) begin
			@(negedge sys_clk);
			t++;
			if (pix_valid_o) begin
				$display("scanout sent a pixel beyond its word count");
				proto_errs++;
			end
		end
		if (scan_busy_o) begin
			$display("scan_busy_o stayed high after the last pixel");
			proto_errs++;
		end
		scan_running = 1'b0;
	endtask

	task automatic start_scan(input logic [`FML_DEPTH-4:0] base, input logic [7:0] words);
		@(negedge sys_clk);
		scan_base_i  = base;
		scan_words_i = words;
		scan_start_i = 1'b1;
		@(negedge sys_clk);
		scan_start_i = 1'b0;
		// Busy from the cycle after the start pulse
		if (scan_busy_o !== 1'b1) begin
			$display("error at %0t: scan_busy_o expected 1 actual %b", $time, scan_busy_o);
			val_errs++;
		end
		scan_running = 1'b1;
		// Host records after this one overlap the scan
		fork
			collect_scan();
		join_none
	endtask

	task automatic wait_scan_idle();
		int t;
		t = 0;
		while (scan_running && t < 20 * WAIT_LIMIT) begin
			@(negedge sys_clk);
			t++;
		end
		if (scan_running) begin
			$display("scanout did not finish");
			proto_errs++;
		end
	endtask

	// --------------------------------------------------
	// Golden file records
	// --------------------------------------------------
	task automatic run_golden(input int fd_in);
		int               code;
		int               idle;
		int               n_words;
		int               i;
		logic [7:0]       kind;
		logic [31:0]      adr;
		logic [31:0]      dat;
		logic [31:0]      rdat;
		logic [3:0]       sel;
		logic [15:0]      pix;
		logic [8*128-1:0] line_buf;
		code = $fscanf(fd_in, " %c", kind);
		while (code == 1) begin
			// Random idle gap before each host cycle
			idle = $random(seed) & 3;
			if (kind == "#") begin
				code = $fgets(line_buf, fd_in);
			end else if (kind == "W") begin
				code = $fscanf(fd_in, "%h %h %h", adr, sel, dat);
				repeat (idle) @(negedge sys_clk);
				host_cycle(1'b1, adr, sel, dat, rdat);
			end else if (kind == "R") begin
				code = $fscanf(fd_in, "%h %h", adr, dat);
				repeat (idle) @(negedge sys_clk);
				host_cycle(1'b0, adr, 4'hf, 32'h0, rdat);
				if (rdat !== dat) begin
					$display("error at %0t: wb_dat_o expected %h actual %h", $time, dat, rdat);
					val_errs++;
				end
			end else if (kind == "S") begin
				wait_scan_idle();
				code = $fscanf(fd_in, "%h %h", adr, n_words);
				for (i = 0; i < 4 * n_words; i++) begin
					code = $fscanf(fd_in, "%h", pix);
					exp_pix.push_back(pix);
				end
				start_scan(adr[`FML_DEPTH-4:0], n_words[7:0]);
			end else begin
				$display("unknown record kind %c in golden file", kind);
				proto_errs++;
			end
			code = $fscanf(fd_in, " %c", kind);
		end
	endtask

	initial begin
		trigger_reset = 1'b1;
		wb_i          = '0;
		scan_start_i  = 1'b0;
		scan_base_i   = '0;
		scan_words_i  = 8'd0;
		repeat (10) @(negedge sys_clk);
		trigger_reset = 1'b0;
		check_reset_order();

		fd = $fopen("verif/fml_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/fml_golden.txt");
			proto_errs++;
		end else begin
			run_golden(fd);
			$fclose(fd);
		end
		wait_scan_idle();

		prop_errs = fml_subsystem_inst.fml_arbiter_inst.fml_arbiter_props_inst.fail_cnt;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			val_errs, proto_errs, prop_errs);
		if (val_errs == 0 && proto_errs == 0 && prop_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
